// File: rtl/regfile_pkg.sv
/* shared types for the 32-bit register file; widths are fixed by the ISA.
   status word layout from msb: cond(4) mask(2) pc word address(24) mode(2) */

package regfile_pkg;

  localparam int unsigned NUM_GPR = 24; // general registers, r0..r23
  localparam int unsigned REG_AW  = 5;  // mapped register address width

  // read port source codes
  localparam logic [1:0] SEL_GPR    = 2'd0; // general register file
  localparam logic [1:0] SEL_IRQ13  = 2'd1; // interrupt r13 copy
  localparam logic [1:0] SEL_SVC13  = 2'd2; // supervisor r13 copy
  localparam logic [1:0] SEL_STATUS = 2'd3; // packed status word

  typedef logic [31:0]       reg_word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  typedef struct packed {
    logic [3:0]  cond;    // datapath flags
    logic [1:0]  mask;    // interrupt mask
    logic [23:0] pc_addr; // word address of the pc
    logic [1:0]  mode;    // processor mode
  } status_fields_t;

  // same 32 bits seen as a bus word or as status fields
  typedef union packed {
    reg_word_t      word;
    status_fields_t fields;
  } status_word_u;

  typedef struct packed {
    reg_addr_t mr_a; // mapped read address a
    reg_addr_t mr_b; // mapped read address b
    reg_addr_t mw_a; // mapped write address
  } rf_addr_t;

  typedef struct packed {
    logic [1:0] sel_a;      // port a source
    logic [1:0] sel_b;      // port b source
    logic       sel_stat;   // 1: flags from cond_in
    logic       sel_mask;   // 1: mask from mask_in
    logic       sel_inc;    // 1: pc from inc_in
    logic       sel_mode;   // 1: mode from mode_in
    logic       en_regfile;
    logic       en_irq13;
    logic       en_svc13;
    logic       en_stat;
    logic       en_mask;
    logic       en_pc_addr;
    logic       en_mode;
  } rf_ctrl_t;

  typedef struct packed {
    logic [3:0]  cond_in; // flags from the alu
    logic [1:0]  mask_in; // mask from the interrupt logic
    logic [25:0] inc_in;  // incremented byte address, [1:0] ignored
    logic [1:0]  mode_in; // mode from the exception logic
  } rf_side_in_t;

endpackage

// File: rtl/gpr_array.sv
/* 24 x 32 general registers, two combinational reads and one write on phi2.
   out-of-range addresses (24..31) ignore writes and read as zero; no bypass */

`timescale 1ns/1ps

module gpr_array (
  input  logic                  phi2,  // write clock
  input  logic                  rst_n,
  input  regfile_pkg::reg_addr_t mr_a, // read address a, already mapped
  input  regfile_pkg::reg_addr_t mr_b, // read address b, already mapped
  input  regfile_pkg::reg_addr_t mw_a, // write address, already mapped
  input  regfile_pkg::reg_word_t w,    // write data
  input  logic                  we,    // write enable
  output regfile_pkg::reg_word_t rd_a,
  output regfile_pkg::reg_word_t rd_b
);

  import regfile_pkg::*;

  localparam reg_addr_t LAST_ADDR = reg_addr_t'(NUM_GPR - 1); // highest valid address

  reg_word_t mem [NUM_GPR]; // register storage

  logic a_ok;  // read a in range
  logic b_ok;  // read b in range
  logic w_ok;  // write in range

  assign a_ok = (mr_a <= LAST_ADDR);
  assign b_ok = (mr_b <= LAST_ADDR);
  assign w_ok = (mw_a <= LAST_ADDR);

  // single write port, whole array cleared on reset
  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        mem[i] <= '0;
      end
    end else if (we && w_ok) begin
      mem[mw_a] <= w; // dropped silently when out of range
    end
  end

  // read port a
  always_comb begin
    rd_a = '0; // unmapped address reads zero
    if (a_ok) begin
      rd_a = mem[mr_a];
    end
  end

  // read port b
  always_comb begin
    rd_b = '0;
    if (b_ok) begin
      rd_b = mem[mr_b];
    end
  end

endmodule

// File: rtl/pc_status_reg.sv
/* flag, mask, pc word address and mode registers, each with its own enable.
   sel_* low takes the slice of w, high takes the dedicated datapath input */

`timescale 1ns/1ps

module pc_status_reg (
  input  logic                     phi2,
  input  logic                     rst_n,
  input  regfile_pkg::reg_word_t    w,      // general write bus
  input  regfile_pkg::rf_side_in_t  side,   // dedicated field inputs
  input  regfile_pkg::rf_ctrl_t     ctrl,   // only status selects and enables used
  output regfile_pkg::status_word_u status  // packed status word
);

  import regfile_pkg::*;

  status_word_u   w_view; // write bus split into status fields
  status_fields_t stat_d; // next value per field
  status_fields_t stat_q; // current fields

  assign w_view.word = w;

  // write-source muxes
  always_comb begin
    stat_d = w_view.fields; // default: load from w
    if (ctrl.sel_stat) begin
      stat_d.cond = side.cond_in;
    end
    if (ctrl.sel_mask) begin
      stat_d.mask = side.mask_in;
    end
    if (ctrl.sel_inc) begin
      stat_d.pc_addr = side.inc_in[25:2]; // drop byte offset
    end
    if (ctrl.sel_mode) begin
      stat_d.mode = side.mode_in;
    end
  end

  // flags
  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      stat_q.cond <= '0;
    end else if (ctrl.en_stat) begin
      stat_q.cond <= stat_d.cond;
    end
  end

  // interrupt mask
  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      stat_q.mask <= '0;
    end else if (ctrl.en_mask) begin
      stat_q.mask <= stat_d.mask;
    end
  end

  // pc word address
  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      stat_q.pc_addr <= '0;
    end else if (ctrl.en_pc_addr) begin
      stat_q.pc_addr <= stat_d.pc_addr;
    end
  end

  // processor mode
  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      stat_q.mode <= '0;
    end else if (ctrl.en_mode) begin
      stat_q.mode <= stat_d.mode;
    end
  end

  assign status.fields = stat_q; // packs back to cond,mask,pc,mode

endmodule

// File: rtl/banked_read_ports.sv
/* banked r13 copies for irq and svc mode plus the two read port muxes.
   both copies load from w only; caller maps r13 to the right source */

`timescale 1ns/1ps

module banked_read_ports (
  input  logic                     phi2,
  input  logic                     rst_n,
  input  regfile_pkg::reg_word_t    w,        // general write bus
  input  logic                     en_irq13, // load irq r13
  input  logic                     en_svc13, // load svc r13
  input  logic [1:0]               sel_a,    // SEL_* code for port a
  input  logic [1:0]               sel_b,    // SEL_* code for port b
  input  regfile_pkg::reg_word_t    gpr_a,    // general register read a
  input  regfile_pkg::reg_word_t    gpr_b,    // general register read b
  input  regfile_pkg::status_word_u status,   // packed status word
  output regfile_pkg::reg_word_t    a,
  output regfile_pkg::reg_word_t    b
);

  import regfile_pkg::*;

  reg_word_t irq13_q; // r13 in interrupt mode
  reg_word_t svc13_q; // r13 in supervisor mode

  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      irq13_q <= '0;
    end else if (en_irq13) begin
      irq13_q <= w;
    end
  end

  always_ff @(posedge phi2 or negedge rst_n) begin
    if (!rst_n) begin
      svc13_q <= '0;
    end else if (en_svc13) begin
      svc13_q <= w;
    end
  end

  // four-way source select shared by both ports
  function automatic reg_word_t port_mux(input logic [1:0] sel, input reg_word_t gpr);
    reg_word_t y;
    unique case (sel)
      SEL_GPR:    y = gpr;
      SEL_IRQ13:  y = irq13_q;
      SEL_SVC13:  y = svc13_q;
      SEL_STATUS: y = status.word; // whole status word
      default:    y = gpr;
    endcase
    return y;
  endfunction

  // banked copies and status are read inside port_mux
  always_comb begin
    a = port_mux(sel_a, gpr_a);
    b = port_mux(sel_b, gpr_b);
  end

endmodule

// File: rtl/regfile_struct.sv
/* register file top: 24 gprs, banked r13 copies and the pc/status word.
   reads are combinational, writes land on the rising phi2 edge, no bypass */

`timescale 1ns/1ps

module regfile_struct (
  input  logic                    phi2,        // write clock
  input  logic                    rst_n,
  input  regfile_pkg::reg_word_t   w,           // general write bus
  input  regfile_pkg::rf_side_in_t side,        // dedicated status inputs
  input  regfile_pkg::rf_addr_t    addr,        // mapped read/write addresses
  input  regfile_pkg::rf_ctrl_t    ctrl,        // selects and enables
  output regfile_pkg::reg_word_t   a,           // read port a
  output regfile_pkg::reg_word_t   b,           // read port b
  output logic [25:0]              pc_addr_out, // byte address, low bits zero
  output logic [1:0]               mode_out,
  output logic [1:0]               mask_out,
  output logic [3:0]               cond_out
);

  import regfile_pkg::*;

  reg_word_t    gpr_a;  // general register read a
  reg_word_t    gpr_b;  // general register read b
  status_word_u status; // packed status

  gpr_array u_gpr_array (
    .phi2  (phi2),
    .rst_n (rst_n),
    .mr_a  (addr.mr_a),
    .mr_b  (addr.mr_b),
    .mw_a  (addr.mw_a),
    .w     (w),
    .we    (ctrl.en_regfile),
    .rd_a  (gpr_a),
    .rd_b  (gpr_b)
  );

  pc_status_reg u_pc_status_reg (
    .phi2   (phi2),
    .rst_n  (rst_n),
    .w      (w),
    .side   (side),
    .ctrl   (ctrl),
    .status (status)
  );

  banked_read_ports u_banked_read_ports (
    .phi2     (phi2),
    .rst_n    (rst_n),
    .w        (w),
    .en_irq13 (ctrl.en_irq13),
    .en_svc13 (ctrl.en_svc13),
    .sel_a    (ctrl.sel_a),
    .sel_b    (ctrl.sel_b),
    .gpr_a    (gpr_a),
    .gpr_b    (gpr_b),
    .status   (status),
    .a        (a),
    .b        (b)
  );

  // field outputs straight from the status word
  assign pc_addr_out = {status.fields.pc_addr, 2'b00}; // word to byte address
  assign mode_out    = status.fields.mode;
  assign mask_out    = status.fields.mask;
  assign cond_out    = status.fields.cond;

endmodule

// File: verif/regfile_struct_assert.sv
/* concurrent checks on the register file top, sampled on the rising phi2 edge.
   the field outputs are packed back into one word for the port a check */

`timescale 1ns/1ps

module regfile_struct_assert (
  input logic                   phi2,
  input logic                   rst_n,
  input regfile_pkg::rf_ctrl_t  ctrl,
  input regfile_pkg::reg_word_t a,
  input regfile_pkg::reg_word_t b,
  input logic [25:0]            pc_addr_out,
  input logic [1:0]             mode_out,
  input logic [1:0]             mask_out,
  input logic [3:0]             cond_out
);

  import regfile_pkg::*;

  reg_word_t status_word; // cond, mask, pc word address, mode from msb

  assign status_word = {cond_out, mask_out, pc_addr_out[25:2], mode_out};

  reset_zero: assert property (@(posedge phi2)
    !rst_n |-> (a == '0 && b == '0 && pc_addr_out == '0 && mode_out == '0
                && mask_out == '0 && cond_out == '0))
    else $error("outputs not zero while rst_n is low");

  pc_low_zero: assert property (@(posedge phi2) pc_addr_out[1:0] == 2'b00)
    else $error("pc_addr_out low bits not zero");

  // mode only moves on an edge that samples en_mode high
  mode_hold: assert property (@(posedge phi2) disable iff (!rst_n)
    !ctrl.en_mode |=> $stable(mode_out))
    else $error("mode_out changed without en_mode");

  status_on_a: assert property (@(posedge phi2)
    ctrl.sel_a == SEL_STATUS |-> a == status_word)
    else $error("port a differs from the status word");

endmodule

bind regfile_struct regfile_struct_assert u_regfile_struct_assert (
  .phi2        (phi2),
  .rst_n       (rst_n),
  .ctrl        (ctrl),
  .a           (a),
  .b           (b),
  .pc_addr_out (pc_addr_out),
  .mode_out    (mode_out),
  .mask_out    (mask_out),
  .cond_out    (cond_out)
);

// File: verif/regfile_struct_tb.sv
/* testbench for the register file top. each row is checked before its own write lands,
   so expected values show the state left by earlier rows */

`timescale 1ns/1ps

module regfile_struct_tb;

  import regfile_pkg::*;

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 10;
  localparam int          NUM_ROWS     = 19;
  localparam int          NUM_RAND     = 64;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + 2 * (NUM_ROWS + NUM_RAND)) * CLK_PERIOD;
  localparam logic [31:0] SEED         = 32'h4ba024c4;

  // enables in rf_ctrl_t order regfile, irq13, svc13, stat, mask, pc, mode
  localparam logic [6:0] EN_NONE   = 7'b0000000;
  localparam logic [6:0] EN_GPR    = 7'b1000000;
  localparam logic [6:0] EN_IRQ    = 7'b0100000;
  localparam logic [6:0] EN_SVC    = 7'b0010000;
  localparam logic [6:0] EN_MASK   = 7'b0000100;
  localparam logic [6:0] EN_PC     = 7'b0000010;
  localparam logic [6:0] EN_MODE   = 7'b0000001;
  localparam logic [6:0] EN_STATUS = 7'b0001111; // all four status fields
  localparam logic [3:0] SRC_W     = 4'b0000;   // every field from w
  localparam logic [3:0] SRC_SIDE  = 4'b1111;   // every field from its side input

  localparam rf_side_in_t SIDE_A = {4'h5, 2'h2, 26'h1234567, 2'h1}; // inc low bits set
  localparam rf_side_in_t SIDE_B = {4'h3, 2'h1, 26'h0000fff, 2'h2};

  // expected status fields as cond mask pc mode
  localparam status_fields_t ST0 = '0;
  localparam status_fields_t ST1 = {4'ha, 2'h1, 24'h123456, 2'h2};
  localparam status_fields_t ST2 = {4'h5, 2'h2, 24'h48d159, 2'h1}; // inc_in >> 2
  localparam status_fields_t ST3 = {4'h5, 2'h3, 24'h48d159, 2'h2};
  localparam status_fields_t ST4 = {4'h5, 2'h3, 24'h0003ff, 2'h2};

  typedef struct {
    string          name;
    rf_addr_t       addr;
    rf_ctrl_t       ctrl;
    reg_word_t      w;
    rf_side_in_t    side;
    reg_word_t      exp_a;
    reg_word_t      exp_b;
    status_fields_t exp_stat;
  } row_t;

  logic        phi2;
  logic        rst_n;
  reg_word_t   w;
  rf_side_in_t side;
  rf_addr_t    addr;
  rf_ctrl_t    ctrl;
  reg_word_t   a;
  reg_word_t   b;
  logic [25:0] pc_addr_out;
  logic [1:0]  mode_out;
  logic [1:0]  mask_out;
  logic [3:0]  cond_out;

  row_t        rows [NUM_ROWS];
  reg_word_t   model [NUM_GPR]; // expected general register contents
  int          n_rows;
  int unsigned fails;

  regfile_struct regfile_struct_i (.*);

  always #(CLK_PERIOD / 2) phi2 = ~phi2;

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  function automatic rf_ctrl_t encode_ctrl(input logic [1:0] sel_a, input logic [1:0] sel_b,
                                           input logic [3:0] src, input logic [6:0] en);
    return {sel_a, sel_b, src, en};
  endfunction

  function automatic rf_addr_t pack_addr(input reg_addr_t mr_a, input reg_addr_t mr_b,
                                         input reg_addr_t mw_a);
    return {mr_a, mr_b, mw_a};
  endfunction

  function automatic reg_word_t model_read(input reg_addr_t ad);
    return (int'(ad) < NUM_GPR) ? model[ad] : '0; // unmapped reads zero
  endfunction

  function automatic status_fields_t outputs_to_status();
    return {cond_out, mask_out, pc_addr_out[25:2], mode_out};
  endfunction

  task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
    if (act !== exp) begin
      fails++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_status(input string name, input status_fields_t exp,
                              input status_fields_t act);
    if (act !== exp) begin
      fails++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic add_row(input string name, input rf_ctrl_t c, input rf_addr_t ad,
                         input reg_word_t wd, input rf_side_in_t sd, input reg_word_t ea,
                         input reg_word_t eb, input status_fields_t es);
    row_t r;
    r.name     = name;
    r.ctrl     = c;
    r.addr     = ad;
    r.w        = wd;
    r.side     = sd;
    r.exp_a    = ea;
    r.exp_b    = eb;
    r.exp_stat = es;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    add_row("reset_gpr", encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_NONE),
            pack_addr(5'd0, 5'd23, 5'd0), 32'h0, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("reset_banked", encode_ctrl(SEL_IRQ13, SEL_SVC13, SRC_W, EN_NONE),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h0, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("reset_status", encode_ctrl(SEL_STATUS, SEL_STATUS, SRC_W, EN_NONE),
            pack_addr(5'd0, 5'd0, 5'd0), 32'hffff_ffff, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("gpr_write_r5", encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_GPR),   // no bypass
            pack_addr(5'd5, 5'd5, 5'd5), 32'hdead_beef, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("gpr_read_r5", encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_GPR),
            pack_addr(5'd5, 5'd5, 5'd24), 32'h1111_1111, SIDE_A, 32'hdead_beef, 32'hdead_beef, ST0);
    add_row("gpr_oor_write", encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_GPR),
            pack_addr(5'd24, 5'd5, 5'd31), 32'h2222_2222, SIDE_A, 32'h0, 32'hdead_beef, ST0);
    add_row("gpr_oor_read", encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_NONE),
            pack_addr(5'd31, 5'd24, 5'd0), 32'h0, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("gpr_write_r13", encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_GPR),
            pack_addr(5'd0, 5'd23, 5'd13), 32'h0000_1313, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("irq13_write", encode_ctrl(SEL_GPR, SEL_IRQ13, SRC_W, EN_IRQ),
            pack_addr(5'd13, 5'd0, 5'd0), 32'haaaa_5555, SIDE_A, 32'h0000_1313, 32'h0, ST0);
    add_row("svc13_write", encode_ctrl(SEL_IRQ13, SEL_SVC13, SRC_W, EN_SVC),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h5a5a_a5a5, SIDE_A, 32'haaaa_5555, 32'h0, ST0);
    add_row("banked_read", encode_ctrl(SEL_SVC13, SEL_GPR, SRC_W, EN_NONE),   // gpr r13 kept
            pack_addr(5'd0, 5'd13, 5'd0), 32'h0, SIDE_A, 32'h5a5a_a5a5, 32'h0000_1313, ST0);
    add_row("stat_from_w", encode_ctrl(SEL_STATUS, SEL_STATUS, SRC_W, EN_STATUS),
            pack_addr(5'd0, 5'd0, 5'd0), 32'ha448_d15a, SIDE_A, 32'h0, 32'h0, ST0);
    add_row("stat_w_read", encode_ctrl(SEL_STATUS, SEL_STATUS, SRC_SIDE, EN_NONE),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h0, SIDE_A, 32'ha448_d15a, 32'ha448_d15a, ST1);
    add_row("stat_from_side", encode_ctrl(SEL_STATUS, SEL_STATUS, SRC_SIDE, EN_STATUS),
            pack_addr(5'd0, 5'd0, 5'd0), 32'hffff_ffff, SIDE_A, 32'ha448_d15a, 32'ha448_d15a, ST1);
    add_row("stat_side_read", encode_ctrl(SEL_STATUS, SEL_STATUS, SRC_W, EN_NONE),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h0, SIDE_A, 32'h5923_4565, 32'h5923_4565, ST2);
    // mask from w, mode from mode_in
    add_row("mask_mode_mixed", encode_ctrl(SEL_STATUS, SEL_STATUS, 4'b0001, EN_MASK | EN_MODE),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h0c00_0000, SIDE_B, 32'h5923_4565, 32'h5923_4565, ST2);
    add_row("mixed_read", encode_ctrl(SEL_STATUS, SEL_GPR, SRC_SIDE, EN_NONE),
            pack_addr(5'd0, 5'd5, 5'd0), 32'hffff_ffff, SIDE_A, 32'h5d23_4566, 32'hdead_beef, ST3);
    add_row("pc_from_w", encode_ctrl(SEL_IRQ13, SEL_SVC13, SRC_W, EN_PC),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h0000_0ffc, SIDE_A, 32'haaaa_5555, 32'h5a5a_a5a5, ST3);
    add_row("final_read", encode_ctrl(SEL_STATUS, SEL_STATUS, SRC_W, EN_NONE),
            pack_addr(5'd0, 5'd0, 5'd0), 32'h0, SIDE_A, 32'h5c00_0ffe, 32'h5c00_0ffe, ST4);
  endtask

  task automatic apply_row(input row_t r);
    @(posedge phi2);
    addr <= r.addr;
    ctrl <= r.ctrl;
    w    <= r.w;
    side <= r.side;
    @(negedge phi2); // reads settled and this row's write not taken yet
    check_word({r.name, "/a"}, r.exp_a, a);
    check_word({r.name, "/b"}, r.exp_b, b);
    check_status(r.name, r.exp_stat, outputs_to_status());
    check_word({r.name, "/pc"}, reg_word_t'({r.exp_stat.pc_addr, 2'b00}),
               reg_word_t'(pc_addr_out)); // byte address with two zero bits appended
    if (r.ctrl.en_regfile && int'(r.addr.mw_a) < NUM_GPR) begin
      model[r.addr.mw_a] = r.w; // lands on the next edge
    end
  endtask

  task automatic run_random(input int count);
    reg_addr_t wa;
    reg_addr_t ra;
    reg_addr_t rb;
    reg_word_t wd;
    for (int n = 0; n < count; n++) begin
      wa = reg_addr_t'($urandom); // covers 24..31 too
      wd = $urandom;
      ra = reg_addr_t'($urandom);
      rb = reg_addr_t'($urandom);
      if ($urandom % 2 == 0) begin
        ra = wa; // same-cycle read of the written word
      end
      @(posedge phi2);
      addr <= pack_addr(ra, rb, wa);
      ctrl <= encode_ctrl(SEL_GPR, SEL_GPR, SRC_W, EN_GPR);
      w    <= wd;
      @(negedge phi2);
      check_word($sformatf("random_%0d/a", n), model_read(ra), a);
      check_word($sformatf("random_%0d/b", n), model_read(rb), b);
      if (int'(wa) < NUM_GPR) begin
        model[wa] = wd;
      end
    end
  endtask

  initial begin
    fails  = 0;
    n_rows = 0;
    phi2   = 1'b0;
    rst_n  = 1'b0; // reset from time zero
    w      = '1;   // writes tried during reset must not land
    side   = '1;
    addr   = '0;
    ctrl   = '1;   // every enable high, status on both ports
    for (int i = 0; i < NUM_GPR; i++) begin
      model[i] = '0;
    end
    void'($urandom(SEED));
    build_table();
    repeat (RESET_CYCLES) @(posedge phi2);
    rst_n <= 1'b1;
    w     <= '0; // idle before the first row
    side  <= '0;
    ctrl  <= '0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end
    run_random(NUM_RAND);
    if (fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/regfile_pkg.sv
rtl/gpr_array.sv
rtl/pc_status_reg.sv
rtl/banked_read_ports.sv
rtl/regfile_struct.sv
verif/regfile_struct_assert.sv
verif/regfile_struct_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the register file testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

TOP=regfile_struct_tb
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module "$TOP" -f sources.f -o "$TOP" \
    > "$LOG" 2>&1 \
  && ./obj_dir/"$TOP" >> "$LOG" 2>&1 \
  || echo "build or simulation ended with an error" >> "$LOG"

cat "$LOG"

grep -qx "Verification passed" "$LOG" \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

exit 0
